// ==== isaPkg.sv ====
package isaPkg;

    //////////////////////////////////////////////////////////////////////
    // primary opcodes, bits 31:26
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,  // r-type, decoded by funct
        opRegimm  = 6'b000001,  // bltz / bgez, decoded by rt
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opSlti    = 6'b001010,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opMul     = 6'b011100,  // special2, r-type layout
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcodeT;

    // r-type function field, bits 5:0
    typedef enum logic [5:0] {
        fnSll = 6'b000000,
        fnSrl = 6'b000010,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnXor = 6'b100110,
        fnNor = 6'b100111,
        fnSlt = 6'b101010
    } functT;

    // regimm uses rt as an opcode extension
    localparam logic [4:0] RtBltz = 5'd0;
    localparam logic [4:0] RtBgez = 5'd1;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        functT       funct;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    // same 32-bit word, two field layouts
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

endpackage

// ==== ctrlPkg.sv ====
package ctrlPkg;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluMul, aluSll, aluSrl, aluAnd, aluOr, aluXor,
        aluNor, aluSlt, aluEq, aluNe, aluGez, aluLtz, aluGtz, aluLez
    } aluOpT;

    typedef enum logic [1:0] {
        memNone = 2'b00,
        memWord = 2'b01,
        memHalf = 2'b10,
        memByte = 2'b11
    } memSizeT;

    typedef struct packed {
        logic    regWrite;
        logic    aluSrc;    // operand b from immediate
        logic    regDst;    // dest from rd, else rt
        logic    memToReg;  // writeback from load data
        logic    branch;
        memSizeT memRead;
        memSizeT memWrite;
        aluOpT   aluOp;
        logic    shiftImm;  // shift amount from shamt
        logic    zeroExt;   // logical immediates
    } ctrlT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] immVal;
        logic [4:0]  shamt;
        logic [4:0]  dest;
    } exStageT;

    typedef struct packed {
        logic        valid;
        ctrlT        ctrl;
        logic [31:0] aluVal;
        logic [31:0] storeVal;
        logic [4:0]  dest;
        logic        taken;
    } resStageT;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] wbData;
        logic        branch;
        logic        taken;
        memSizeT     memWrite;
        logic [31:0] memAddr;
        logic [31:0] storeData;  // lanes already placed
    } retireT;

endpackage

// ==== regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // one read port, write-through for same-cycle writes
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;  // r0 hardwired
        end else if (wrEn && wrAddr == addr) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

// ==== mipsDecode.sv ====
module mipsDecode
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instrT       instr,
    input  logic        instrValid,
    output logic [4:0]  rdAddrA,
    output logic [4:0]  rdAddrB,
    input  logic [31:0] rdDataA,
    input  logic [31:0] rdDataB,
    input  resStageT    exFwd,
    input  logic        wbEn,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    output exStageT     exStage
);

    ctrlT        ctrl;
    logic        functOk;
    logic [31:0] immVal;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [4:0]  dest;

    //////////////////////////////////////////////////////////////////////
    // main controller
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl = '0;
        functOk = 1'b1;
        case (instr.r.opcode)
            opSpecial: begin
                case (instr.r.funct)
                    fnSll: begin
                        ctrl.aluOp = aluSll;
                        ctrl.shiftImm = 1'b1;
                    end
                    fnSrl: begin
                        ctrl.aluOp = aluSrl;
                        ctrl.shiftImm = 1'b1;
                    end
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnNor:   ctrl.aluOp = aluNor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: functOk = 1'b0;  // jr and friends
                endcase
                ctrl.regWrite = functOk;
                ctrl.regDst = functOk;
            end
            opMul: begin  // funct field not checked
                ctrl.regWrite = 1'b1;
                ctrl.regDst = 1'b1;
                ctrl.aluOp = aluMul;
            end
            opRegimm: begin
                case (instr.i.rt)
                    RtBltz:  ctrl.aluOp = aluLtz;
                    RtBgez:  ctrl.aluOp = aluGez;
                    default: functOk = 1'b0;
                endcase
                ctrl.branch = functOk;
            end
            opBeq: {ctrl.branch, ctrl.aluOp} = {1'b1, aluEq};
            opBne: {ctrl.branch, ctrl.aluOp} = {1'b1, aluNe};
            opBlez: {ctrl.branch, ctrl.aluOp} = {1'b1, aluLez};
            opBgtz: {ctrl.branch, ctrl.aluOp} = {1'b1, aluGtz};
            opAddi, opSlti, opAndi, opOri, opXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                case (instr.i.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluAdd;
                endcase
                ctrl.zeroExt = ctrl.aluOp inside {aluAnd, aluOr, aluXor};
            end
            opLw, opLh, opLb: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;  // address = rs + imm
                ctrl.memToReg = 1'b1;
                ctrl.memRead = (instr.i.opcode == opLw) ? memWord :
                               (instr.i.opcode == opLh) ? memHalf : memByte;
            end
            opSw, opSh, opSb: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = (instr.i.opcode == opSw) ? memWord :
                                (instr.i.opcode == opSh) ? memHalf : memByte;
            end
            default: ctrl = '0;  // j, jal and anything unknown
        endcase
    end

    assign immVal = ctrl.zeroExt ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
    assign dest = ctrl.regDst ? instr.r.rd : instr.r.rt;

    //////////////////////////////////////////////////////////////////////
    // operand read and forwarding
    //////////////////////////////////////////////////////////////////////
    assign rdAddrA = instr.i.rs;
    assign rdAddrB = instr.i.rt;

    // youngest producer wins; loads in execute have no data yet
    function automatic logic [31:0] fwdOperand(input logic [4:0] addr, input logic [31:0] rfVal);
        if (addr == 5'd0) begin
            return rfVal;
        end else if (exFwd.valid && exFwd.ctrl.regWrite && !exFwd.ctrl.memToReg
                     && exFwd.dest == addr) begin
            return exFwd.aluVal;
        end else if (wbEn && wbAddr == addr) begin
            return wbData;
        end
        return rfVal;
    endfunction

    always_comb begin
        rsVal = fwdOperand(rdAddrA, rdDataA);
        rtVal = fwdOperand(rdAddrB, rdDataB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exStage <= '0;
        end else begin
            exStage.valid <= instrValid;
            exStage.ctrl <= ctrl;
            exStage.rsVal <= rsVal;
            exStage.rtVal <= rtVal;
            exStage.immVal <= immVal;
            exStage.shamt <= instr.r.shamt;
            exStage.dest <= dest;
        end
    end

endmodule

// ==== mipsExecute.sv ====
module mipsExecute
    import ctrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  exStageT  exStage,
    output resStageT resStage,
    output resStageT exFwd
);

    logic [31:0] opB;
    logic [4:0]  shAmt;
    logic        cond;
    logic [31:0] aluVal;

    assign opB = exStage.ctrl.aluSrc ? exStage.immVal : exStage.rtVal;
    assign shAmt = exStage.ctrl.shiftImm ? exStage.shamt : exStage.rsVal[4:0];

    //////////////////////////////////////////////////////////////////////
    // branch condition
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (exStage.ctrl.aluOp)
            aluEq:   cond = exStage.rsVal == exStage.rtVal;
            aluNe:   cond = exStage.rsVal != exStage.rtVal;
            aluGez:  cond = !exStage.rsVal[31];
            aluLtz:  cond = exStage.rsVal[31];
            aluGtz:  cond = !exStage.rsVal[31] && exStage.rsVal != '0;
            aluLez:  cond = exStage.rsVal[31] || exStage.rsVal == '0;
            default: cond = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (exStage.ctrl.aluOp)
            aluAdd:  aluVal = exStage.rsVal + opB;
            aluSub:  aluVal = exStage.rsVal - opB;
            aluMul:  aluVal = $signed(exStage.rsVal) * $signed(opB);  // low word
            aluSll:  aluVal = exStage.rtVal << shAmt;
            aluSrl:  aluVal = exStage.rtVal >> shAmt;
            aluAnd:  aluVal = exStage.rsVal & opB;
            aluOr:   aluVal = exStage.rsVal | opB;
            aluXor:  aluVal = exStage.rsVal ^ opB;
            aluNor:  aluVal = ~(exStage.rsVal | opB);
            aluSlt:  aluVal = {31'b0, $signed(exStage.rsVal) < $signed(opB)};
            default: aluVal = {31'b0, cond};  // compare ops
        endcase
    end

    // stage contents seen by decode forwarding
    always_comb begin
        exFwd.valid = exStage.valid;
        exFwd.ctrl = exStage.ctrl;
        exFwd.aluVal = aluVal;
        exFwd.storeVal = exStage.rtVal;
        exFwd.dest = exStage.dest;
        exFwd.taken = exStage.ctrl.branch && cond;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resStage <= '0;
        end else begin
            resStage <= exFwd;
        end
    end

endmodule

// ==== mipsResult.sv ====
module mipsResult
    import ctrlPkg::*;
#(
    parameter int DataMemWords = 256  // power of two
) (
    input  logic        clk,
    input  logic        rstN,
    input  resStageT    resStage,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData,
    output retireT      retire
);

    localparam int AddrBits = $clog2(DataMemWords * 4);

    logic [31:0] mem [DataMemWords];
    logic [31:0] memAddr;
    logic [31:0] rdWord;
    logic [1:0]  byteOff;
    logic [31:0] loadVal;
    logic [3:0]  laneMask;
    logic [31:0] laneData;
    logic [31:0] placed;
    logic        stEn;
    retireT      retireNext;

    assign memAddr = {{(32 - AddrBits){1'b0}}, resStage.aluVal[AddrBits-1:0]};  // wraps
    assign byteOff = memAddr[1:0];
    assign rdWord = mem[memAddr[AddrBits-1:2]];
    assign stEn = resStage.valid && resStage.ctrl.memWrite != memNone;

    //////////////////////////////////////////////////////////////////////
    // sized loads, little endian, sign extended
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (resStage.ctrl.memRead)
            memHalf: loadVal = byteOff[1] ? {{16{rdWord[31]}}, rdWord[31:16]}
                                          : {{16{rdWord[15]}}, rdWord[15:0]};
            memByte: loadVal = {{24{rdWord[8*byteOff+7]}}, rdWord[8*byteOff +: 8]};
            default: loadVal = rdWord;
        endcase
    end

    // store lanes
    always_comb begin
        case (resStage.ctrl.memWrite)
            memWord: {laneMask, laneData} = {4'b1111, resStage.storeVal};
            memHalf: {laneMask, laneData} = {byteOff[1] ? 4'b1100 : 4'b0011,
                                             {2{resStage.storeVal[15:0]}}};
            memByte: {laneMask, laneData} = {4'b0001 << byteOff, {4{resStage.storeVal[7:0]}}};
            default: {laneMask, laneData} = '0;
        endcase
        for (int b = 0; b < 4; b++) begin
            placed[8*b +: 8] = laneMask[b] ? laneData[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DataMemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (stEn) begin
            for (int b = 0; b < 4; b++) begin
                if (laneMask[b]) begin
                    mem[memAddr[AddrBits-1:2]][8*b +: 8] <= placed[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // writeback and retire record
    //////////////////////////////////////////////////////////////////////
    assign wbEn = resStage.valid && resStage.ctrl.regWrite;
    assign wbAddr = resStage.dest;
    assign wbData = resStage.ctrl.memToReg ? loadVal : resStage.aluVal;

    always_comb begin
        retireNext.valid = resStage.valid;
        retireNext.regWrite = wbEn;
        retireNext.dest = wbEn ? wbAddr : 5'd0;
        retireNext.wbData = wbEn ? wbData : '0;
        retireNext.branch = resStage.valid && resStage.ctrl.branch;
        retireNext.taken = resStage.valid && resStage.taken;
        retireNext.memWrite = stEn ? resStage.ctrl.memWrite : memNone;
        retireNext.memAddr = stEn ? memAddr : '0;
        retireNext.storeData = stEn ? placed : '0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retire <= '0;
        end else begin
            retire <= retireNext;
        end
    end

endmodule

// ==== mipsCore.sv ====
module mipsCore
    import isaPkg::*;
    import ctrlPkg::*;
#(
    parameter int DataMemWords = 256
) (
    input  logic   clk,
    input  logic   rstN,
    input  instrT  instr,
    input  logic   instrValid,
    output retireT retire
);

    logic [4:0]  rdAddrA;
    logic [4:0]  rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    exStageT     exStage;
    resStageT    resStage;
    resStageT    exFwd;

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .wrEn    (wbEn),
        .wrAddr  (wbAddr),
        .wrData  (wbData),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    mipsDecode mipsDecode_i (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .exFwd      (exFwd),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .exStage    (exStage)
    );

    mipsExecute mipsExecute_i (
        .clk      (clk),
        .rstN     (rstN),
        .exStage  (exStage),
        .resStage (resStage),
        .exFwd    (exFwd)
    );

    mipsResult #(
        .DataMemWords (DataMemWords)
    ) mipsResult_i (
        .clk      (clk),
        .rstN     (rstN),
        .resStage (resStage),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .retire   (retire)
    );

endmodule

// ==== mipsCoreTb.sv ====
module mipsCoreTb
    import isaPkg::*;
    import ctrlPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DataMemWords = 256;
    localparam int MemBytes = DataMemWords * 4;
    localparam int NumInstr = 600;
    localparam int WatchdogNs = (NumInstr * 3 + 50) * 4;  // three cycles per instr plus margin

    logic   clk;
    logic   rstN;
    instrT  instrDrv;
    logic   instrValid;
    retireT retire;

    logic [31:0] rngState;
    int          cyc;
    logic [31:0] refRegs [32];
    logic [31:0] refMem [DataMemWords];
    retireT      expQ[$];
    int          expCycQ[$];
    string       expNameQ[$];
    string       names [28];

    mipsCore #(
        .DataMemWords (DataMemWords)
    ) mipsCore_i (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instrDrv),
        .instrValid (instrValid),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // retire checking, once per falling edge
    //////////////////////////////////////////////////////////////////////
    task automatic checkRetire();
        if (retire.valid) begin
            assert (expQ.size() > 0)
                else abortRun($sformatf("retire.valid at cycle %0d with nothing in flight", cyc));
            assert (expCycQ[0] == cyc)
                else abortRun($sformatf("Mismatch %s retire cycle: expected %0d actual %0d",
                                        expNameQ[0], expCycQ[0], cyc));
            assert (retire == expQ[0])
                else abortRun($sformatf("Mismatch %s: expected %h actual %h",
                                        expNameQ[0], expQ[0], retire));
            void'(expQ.pop_front());
            void'(expCycQ.pop_front());
            void'(expNameQ.pop_front());
        end else begin
            assert (expQ.size() == 0 || expCycQ[0] != cyc)
                else abortRun($sformatf("%s did not retire at cycle %0d", expNameQ[0], cyc));
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cyc++;
        checkRetire();
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, one instruction in program order
    //////////////////////////////////////////////////////////////////////
    task automatic modelExecute(input logic [31:0] w, input string nm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] v;
        logic [3:0]  mask;
        logic        doWrite;
        logic [4:0]  d;
        int          idx;
        retireT      exp;
        a = refRegs[w[25:21]];
        b = refRegs[w[20:16]];
        sImm = {{16{w[15]}}, w[15:0]};
        addr = (a + sImm) & 32'(MemBytes - 1);  // wraps inside data memory
        idx = int'(addr >> 2);
        word = refMem[idx];
        exp = '0;
        exp.valid = 1'b1;
        doWrite = 1'b1;
        d = w[20:16];
        v = '0;
        mask = 4'b0000;
        case (w[31:26])
            6'h00: begin
                d = w[15:11];
                case (w[5:0])
                    6'h00:   v = b << w[10:6];
                    6'h02:   v = b >> w[10:6];
                    6'h20:   v = a + b;
                    6'h22:   v = a - b;
                    6'h24:   v = a & b;
                    6'h25:   v = a | b;
                    6'h26:   v = a ^ b;
                    6'h27:   v = ~(a | b);
                    6'h2a:   v = {31'b0, $signed(a) < $signed(b)};
                    default: doWrite = 1'b0;  // jr and unknown functs
                endcase
            end
            6'h1c: begin
                d = w[15:11];
                v = a * b;  // low word of product
            end
            6'h08: v = a + sImm;
            6'h0a: v = {31'b0, $signed(a) < $signed(sImm)};
            6'h0c: v = a & {16'b0, w[15:0]};
            6'h0d: v = a | {16'b0, w[15:0]};
            6'h0e: v = a ^ {16'b0, w[15:0]};
            6'h23: v = word;
            6'h21: v = addr[1] ? {{16{word[31]}}, word[31:16]} : {{16{word[15]}}, word[15:0]};
            6'h20: begin
                v = word >> (8 * addr[1:0]);
                v = {{24{v[7]}}, v[7:0]};
            end
            6'h2b, 6'h29, 6'h28: begin
                doWrite = 1'b0;
                exp.memAddr = addr;
                if (w[27]) begin
                    exp.memWrite = memWord;
                    mask = 4'b1111;
                    exp.storeData = b;
                end else if (w[26]) begin
                    exp.memWrite = memHalf;
                    mask = addr[1] ? 4'b1100 : 4'b0011;
                    exp.storeData = addr[1] ? {b[15:0], 16'b0} : {16'b0, b[15:0]};
                end else begin
                    exp.memWrite = memByte;
                    mask = 4'b0001 << addr[1:0];
                    exp.storeData = {24'b0, b[7:0]} << (8 * addr[1:0]);
                end
                for (int k = 0; k < 4; k++) begin
                    if (mask[k]) begin
                        refMem[idx][8*k +: 8] = exp.storeData[8*k +: 8];
                    end
                end
            end
            6'h01: begin
                doWrite = 1'b0;
                exp.branch = w[20:17] == 4'b0000;  // bltz or bgez only
                exp.taken = exp.branch && (w[16] ? !a[31] : a[31]);
            end
            6'h04, 6'h05, 6'h06, 6'h07: begin
                doWrite = 1'b0;
                exp.branch = 1'b1;
                case (w[27:26])
                    2'd0:    exp.taken = a == b;
                    2'd1:    exp.taken = a != b;
                    2'd2:    exp.taken = $signed(a) <= 0;
                    default: exp.taken = $signed(a) > 0;
                endcase
            end
            default: doWrite = 1'b0;  // jumps and unknown opcodes
        endcase
        if (doWrite) begin
            exp.regWrite = 1'b1;
            exp.dest = d;
            exp.wbData = v;
            if (d != 5'd0) begin
                refRegs[d] = v;
            end
        end
        expQ.push_back(exp);
        expCycQ.push_back(cyc + 3);
        expNameQ.push_back(nm);
    endtask

    // random word of one kind; registers kept to r0..r7 so operands collide
    function automatic logic [31:0] makeInstr(input int kind);
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] memOff;
        r = nextRand();
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = {2'b00, r[8:6]};
        memOff = {{10{r[13]}}, r[13:10], 2'b00};  // word slots -32..28
        case (kind)
            0:  w = {6'h00, rs, rt, rd, 5'd0, 6'h20};
            1:  w = {6'h00, rs, rt, rd, 5'd0, 6'h22};
            2:  w = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3:  w = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4:  w = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            5:  w = {6'h00, rs, rt, rd, 5'd0, 6'h27};
            6:  w = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            7:  w = {6'h00, 5'd0, rt, rd, r[14:10], 6'h00};
            8:  w = {6'h00, 5'd0, rt, rd, r[14:10], 6'h02};
            9:  w = {6'h1c, rs, rt, rd, 5'd0, 6'h02};
            10: w = {6'h08, rs, rt, r[31:16]};
            11: w = {6'h0a, rs, rt, r[31:16]};
            12: w = {6'h0c, rs, rt, r[31:16]};
            13: w = {6'h0d, rs, rt, r[31:16]};
            14: w = {6'h0e, rs, rt, r[31:16]};
            15: w = {6'h23, 5'd0, rt, memOff};
            16: w = {6'h21, 5'd0, rt, memOff | {14'b0, r[14], 1'b0}};
            17: w = {6'h20, 5'd0, rt, memOff | {14'b0, r[15:14]}};
            18: w = {6'h2b, 5'd0, rt, memOff};
            19: w = {6'h29, 5'd0, rt, memOff | {14'b0, r[14], 1'b0}};
            20: w = {6'h28, 5'd0, rt, memOff | {14'b0, r[15:14]}};
            21: w = {6'h04, rs, rt, r[31:16]};
            22: w = {6'h05, rs, rt, r[31:16]};
            23: w = {6'h01, rs, 5'd1, r[31:16]};
            24: w = {6'h01, rs, 5'd0, r[31:16]};
            25: w = {6'h07, rs, 5'd0, r[31:16]};
            26: w = {6'h06, rs, 5'd0, r[31:16]};
            default: begin
                case (r[18:16])
                    3'd0:    w = {6'h02, r[25:0]};  // j
                    3'd1:    w = {6'h03, r[25:0]};  // jal
                    3'd2:    w = {6'h00, rs, 15'd0, 6'h08};  // jr
                    3'd3:    w = {6'h01, rs, 5'd5, r[31:16]};
                    3'd4:    w = {6'h3f, r[25:0]};
                    3'd5:    w = {6'h00, rs, rt, rd, 5'd0, 6'h3b};
                    default: w = {6'h0f, rs, rt, r[31:16]};
                endcase
            end
        endcase
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] w;
        int          kind;
        logic        gap;
        logic        ldPending;
        logic [4:0]  ldDest;
        rngState = 32'd21290;
        names = '{"add", "sub", "and", "or", "xor", "nor", "slt", "sll", "srl", "mul",
                  "addi", "slti", "andi", "ori", "xori", "lw", "lh", "lb", "sw", "sh",
                  "sb", "beq", "bne", "bgez", "bltz", "bgtz", "blez", "unsupported"};
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < DataMemWords; i++) begin
            refMem[i] = '0;
        end
        cyc = 0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instrDrv = '0;
        ldPending = 1'b0;
        ldDest = 5'd0;
        repeat (3) stepCycle();
        rstN = 1'b1;
        for (int n = 0; n < NumInstr; n++) begin
            kind = int'(nextRand() % 32'd28);
            w = makeInstr(kind);
            gap = (nextRand() % 32'd8) == 32'd0;
            if (ldPending && (w[25:21] == ldDest || w[20:16] == ldDest)) begin
                gap = 1'b1;  // no load-use interlock in the core
            end
            if (gap) begin
                stepCycle();
                instrValid = 1'b0;
                instrDrv = nextRand();  // junk while idle
            end
            stepCycle();
            instrValid = 1'b1;
            instrDrv = w;
            modelExecute(w, names[kind]);
            ldPending = kind >= 15 && kind <= 17;
            ldDest = w[20:16];
        end
        stepCycle();
        instrValid = 1'b0;
        instrDrv = '0;
        repeat (4) stepCycle();  // drain the pipeline and stay quiet
        if (expQ.size() != 0) begin
            abortRun($sformatf("%0d instructions never retired", expQ.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    initial begin
        #(WatchdogNs);
        abortRun($sformatf("watchdog expired at cycle %0d before the program drained", cyc));
    end

endmodule

// ==== mipsCore.f ====
isaPkg.sv
ctrlPkg.sv
regFile.sv
mipsDecode.sv
mipsExecute.sv
mipsResult.sv
mipsCore.sv
mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mipsCoreTb -f mipsCore.f -o mipsCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/mipsCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ] || ! grep -q '^>>> PASS$' sim.log; then
    echo "simulation failed"
    exit 1
fi
exit 0
